// ==== Bender.yml ====
package:
  name: fp_addsub

dependencies: {}

sources:
  # packages first, then the interface and the pipeline stages
  - fp_format_pkg.sv
  - fp_op_pkg.sv
  - fp_sum_if.sv
  - fp_align_add.sv
  - fp_special_case.sv
  - fp_round_pack.sv
  - fp_addsub_top.sv
  - target: test
    files:
      - tb_fp_addsub.sv

// ==== build.f ====
fp_format_pkg.sv
fp_op_pkg.sv
fp_sum_if.sv
fp_align_add.sv
fp_special_case.sv
fp_round_pack.sv
fp_addsub_top.sv
tb_fp_addsub.sv

// ==== fp_addsub_top.sv ====
// single precision add and subtract unit, three stage pipeline top level
`timescale 1ns/1ps

module fp_addsub_top
   import fp_format_pkg::*;
   import fp_op_pkg::*;
(
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  in_valid,
   input  logic                  op,
   input  logic [2:0]            frm,
   input  logic [31:0]           operand_a,
   input  logic [31:0]           operand_b,
   output logic                  out_valid,
   output logic [31:0]           result,
   output logic [flag_width-1:0] flags
);

   // special result, lined up with the sum bus
   logic        spec_hit;
   logic        spec_invalid;
   logic [31:0] spec_value;

   fp_sum_if sum_bus ();

   // exponent align and significand add
   fp_align_add u_align (
      .clk       (clk),
      .reset     (reset),
      .in_valid  (in_valid),
      .op        (fp_op_e'(op)),
      .frm       (round_mode_e'(frm)),
      .operand_a (operand_a),
      .operand_b (operand_b),
      .sum       (sum_bus.source)
   );

   // nan and infinity path, runs beside the datapath
   fp_special_case u_special (
      .clk          (clk),
      .reset        (reset),
      .in_valid     (in_valid),
      .op           (fp_op_e'(op)),
      .operand_a    (operand_a),
      .operand_b    (operand_b),
      .spec_hit     (spec_hit),
      .spec_invalid (spec_invalid),
      .spec_value   (spec_value)
   );

   // normalize, round and merge
   fp_round_pack u_round (
      .clk          (clk),
      .reset        (reset),
      .sum          (sum_bus.sink),
      .spec_hit     (spec_hit),
      .spec_invalid (spec_invalid),
      .spec_value   (spec_value),
      .out_valid    (out_valid),
      .result       (result),
      .flags        (flags)
   );

endmodule

// ==== fp_align_add.sv ====
// align and add stages, exponent compare, significand shift with sticky, add or subtract
`timescale 1ns/1ps

module fp_align_add
   import fp_format_pkg::*;
   import fp_op_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        in_valid,
   input  fp_op_e      op,
   input  round_mode_e frm,
   input  logic [31:0] operand_a,
   input  logic [31:0] operand_b,
   fp_sum_if.source    sum
);

   // unpacked operands
   logic                  sign_a;
   logic                  sign_b;
   logic [exp_width-1:0]  exp_a;
   logic [exp_width-1:0]  exp_b;
   logic [frac_width:0]   sig_a;
   logic [frac_width:0]   sig_b;

   // operands after the swap
   logic                  a_larger;
   logic                  sign_big;
   logic [exp_width-1:0]  exp_big;
   logic [exp_width-1:0]  exp_diff;
   logic [frac_width:0]   sig_big;
   logic [frac_width:0]   sig_small;
   logic [mant_width-1:0] small_ext;
   logic [mant_width-1:0] small_shifted;
   logic                  sticky_bit;

   // stage one registers
   logic                  s1_valid;
   logic                  s1_eff_sub;
   logic                  s1_sign_big;
   logic [exp_width-1:0]  s1_exp;
   logic [mant_width-1:0] s1_mant_big;
   logic [mant_width-1:0] s1_mant_small;
   round_mode_e           s1_frm;

   // stage two result
   logic [mant_width:0]   mant_sum;
   logic                  cancel;

   always_comb begin
      sign_a = operand_a[31];
      // subtract is add with b negated
      sign_b = operand_b[31] ^ (op == OP_SUB);
      exp_a  = operand_a[30:23];
      exp_b  = operand_b[30:23];
      // subnormals flush to zero, the sign stays
      sig_a  = (exp_a == '0) ? '0 : {1'b1, operand_a[frac_width-1:0]};
      sig_b  = (exp_b == '0) ? '0 : {1'b1, operand_b[frac_width-1:0]};

      // magnitude compare on the flushed values
      a_larger = {exp_a, sig_a[frac_width-1:0]} >= {exp_b, sig_b[frac_width-1:0]};
      if (a_larger) begin
         sign_big  = sign_a;
         exp_big   = exp_a;
         exp_diff  = exp_a - exp_b;
         sig_big   = sig_a;
         sig_small = sig_b;
      end else begin
         sign_big  = sign_b;
         exp_big   = exp_b;
         exp_diff  = exp_b - exp_a;
         sig_big   = sig_b;
         sig_small = sig_a;
      end

      // three zero bits make room for guard, round and sticky
      small_ext     = {sig_small, 3'b000};
      small_shifted = small_ext >> exp_diff;
      // any bit shifted past the sticky position folds into sticky
      sticky_bit    = |(small_ext & ~({mant_width{1'b1}} << exp_diff));
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         s1_valid <= 1'b0;
      end else begin
         s1_valid <= in_valid;
      end
   end

   always_ff @(posedge clk) begin
      s1_eff_sub    <= sign_a ^ sign_b;
      s1_sign_big   <= sign_big;
      s1_exp        <= exp_big;
      s1_mant_big   <= {sig_big, 3'b000};
      s1_mant_small <= {small_shifted[mant_width-1:1], small_shifted[0] | sticky_bit};
      s1_frm        <= frm;
   end

   always_comb begin
      // one extra bit keeps the carry of an add
      if (s1_eff_sub) begin
         mant_sum = {1'b0, s1_mant_big} - {1'b0, s1_mant_small};
      end else begin
         mant_sum = {1'b0, s1_mant_big} + {1'b0, s1_mant_small};
      end
      cancel = (mant_sum == '0);
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         sum.valid <= 1'b0;
      end else begin
         sum.valid <= s1_valid;
      end
   end

   always_ff @(posedge clk) begin
      // x - x is +0, or -0 when rounding down
      // like-signed zeros keep their common sign
      sum.sign       <= (cancel && s1_eff_sub) ? (s1_frm == RDN) : s1_sign_big;
      sum.exp        <= s1_exp;
      sum.mant       <= mant_sum;
      sum.frm        <= s1_frm;
      sum.exact_zero <= cancel;
   end

   // equal exponents lose no bits in the alignment
   // guard, round and sticky of the registered operand stay clear
   a_no_sticky_on_equal_exp : assert property (
      @(posedge clk) disable iff (reset)
      in_valid && (exp_diff == '0) |=> (s1_mant_small[2:0] == '0)
   );

endmodule

// ==== fp_format_pkg.sv ====
// binary32 format package, field widths, special encodings and exception flag layout
package fp_format_pkg;

   // field sizes of an ieee-754 single
   localparam int exp_width  = 8;
   localparam int frac_width = 23;
   localparam int exp_bias   = 127;

   // all ones exponent marks infinity or nan
   localparam logic [exp_width-1:0] exp_max = 8'hff;

   // working significand: hidden bit, fraction, then guard, round and sticky
   localparam int mant_width = frac_width + 4;

   // canonical quiet nan, the only nan this unit ever produces
   localparam logic [31:0] qnan_canon = 32'h7fc0_0000;

   // infinities
   localparam logic [31:0] pos_inf = 32'h7f80_0000;
   localparam logic [31:0] neg_inf = 32'hff80_0000;

   // largest finite magnitude, sign bit clear
   localparam logic [31:0] max_finite = 32'h7f7f_ffff;

   // flag word, same order as risc-v fflags with dz left out
   localparam int flag_width = 4;
   localparam int flag_nv    = 3;
   localparam int flag_of    = 2;
   localparam int flag_uf    = 1;
   localparam int flag_nx    = 0;

endpackage

// ==== fp_op_pkg.sv ====
// operation package, opcode and rounding mode encodings and pipeline depth
package fp_op_pkg;

   // add or subtract select
   typedef enum logic {
      OP_ADD = 1'b0,
      OP_SUB = 1'b1
   } fp_op_e;

   // rounding modes, risc-v frm encoding
   typedef enum logic [2:0] {
      RNE = 3'd0,
      RTZ = 3'd1,
      RDN = 3'd2,
      RUP = 3'd3,
      RMM = 3'd4
   } round_mode_e;

   // cycles from in_valid to out_valid
   localparam int pipe_latency = 3;

endpackage

// ==== fp_round_pack.sv ====
// round stage, normalize, round by mode, range checks, special merge and flags
`timescale 1ns/1ps

module fp_round_pack
   import fp_format_pkg::*;
   import fp_op_pkg::*;
(
   input  logic                  clk,
   input  logic                  reset,
   fp_sum_if.sink                sum,
   input  logic                  spec_hit,
   input  logic                  spec_invalid,
   input  logic [31:0]           spec_value,
   output logic                  out_valid,
   output logic [31:0]           result,
   output logic [flag_width-1:0] flags
);

   // leading zero count of the 27 bit significand
   function automatic logic [4:0] count_lz(input logic [mant_width-1:0] value);
      logic [4:0] count;
      logic       found;
      count = '0;
      found = 1'b0;
      for (int i = mant_width - 1; i >= 0; i--) begin
         if (!found) begin
            if (value[i]) begin
               found = 1'b1;
            end else begin
               count = count + 5'd1;
            end
         end
      end
      return count;
   endfunction

   logic                        carry;
   logic [4:0]                  lzc;
   logic [mant_width-1:0]       norm;
   logic signed [exp_width+1:0] exp_norm;
   logic signed [exp_width+1:0] exp_rnd;
   logic                        guard_bit;
   logic                        round_bit;
   logic                        sticky_bit;
   logic                        inexact;
   logic                        round_up;
   logic [frac_width+1:0]       rounded;
   logic                        tiny;
   logic                        huge;
   logic                        ovf_to_inf;
   logic [31:0]                 arith_value;
   logic [flag_width-1:0]       arith_flags;
   logic [flag_width-1:0]       spec_flags;

   // normalize
   always_comb begin
      carry = sum.mant[mant_width];
      lzc   = count_lz(sum.mant[mant_width-1:0]);
      if (carry) begin
         // one place right, the dropped bit joins sticky
         norm     = {sum.mant[mant_width:2], sum.mant[1] | sum.mant[0]};
         exp_norm = $signed({2'b00, sum.exp}) + 10'sd1;
      end else begin
         // only small exponent differences cancel, so the shifted-in zeros are exact
         norm     = sum.mant[mant_width-1:0] << lzc;
         exp_norm = $signed({2'b00, sum.exp}) - $signed({5'b00000, lzc});
      end
   end

   // round
   always_comb begin
      guard_bit  = norm[2];
      round_bit  = norm[1];
      sticky_bit = norm[0];
      inexact    = guard_bit | round_bit | sticky_bit;
      case (sum.frm)
         RNE:     round_up = guard_bit & (round_bit | sticky_bit | norm[3]);
         RTZ:     round_up = 1'b0;
         RDN:     round_up = sum.sign & inexact;
         RUP:     round_up = ~sum.sign & inexact;
         RMM:     round_up = guard_bit;
         default: round_up = 1'b0;
      endcase
      rounded = {1'b0, norm[mant_width-1:3]} + {{(frac_width+1){1'b0}}, round_up};
      // carry out of the significand leaves 1.000, one exponent up
      exp_rnd = exp_norm + $signed({{(exp_width+1){1'b0}}, rounded[frac_width+1]});

      tiny = exp_norm < 10'sd1;
      huge = exp_rnd >= $signed({2'b00, exp_max});

      // ieee overflow result per mode and sign
      case (sum.frm)
         RNE, RMM: ovf_to_inf = 1'b1;
         RUP:      ovf_to_inf = ~sum.sign;
         RDN:      ovf_to_inf = sum.sign;
         default:  ovf_to_inf = 1'b0;
      endcase
   end

   // arithmetic result and flags
   always_comb begin
      arith_flags = '0;
      if (sum.exact_zero) begin
         // sign already resolved upstream
         arith_value = {sum.sign, 31'b0};
      end else if (tiny) begin
         // flush to signed zero
         arith_value          = {sum.sign, 31'b0};
         arith_flags[flag_uf] = 1'b1;
         arith_flags[flag_nx] = 1'b1;
      end else if (huge) begin
         if (ovf_to_inf) begin
            arith_value = sum.sign ? neg_inf : pos_inf;
         end else begin
            arith_value = {sum.sign, max_finite[30:0]};
         end
         arith_flags[flag_of] = 1'b1;
         arith_flags[flag_nx] = 1'b1;
      end else begin
         arith_value          = {sum.sign, exp_rnd[exp_width-1:0], rounded[frac_width-1:0]};
         arith_flags[flag_nx] = inexact;
      end

      // special results only ever raise nv
      spec_flags          = '0;
      spec_flags[flag_nv] = spec_invalid;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         out_valid <= 1'b0;
         result    <= '0;
         flags     <= '0;
      end else begin
         out_valid <= sum.valid;
         result    <= spec_hit ? spec_value : arith_value;
         flags     <= spec_hit ? spec_flags : arith_flags;
      end
   end

   // the only nan leaving the unit is the canonical one
   a_canonical_nan_only : assert property (
      @(posedge clk) disable iff (reset)
      out_valid && (result[30:23] == exp_max) && (result[frac_width-1:0] != '0)
         |-> (result == qnan_canon)
   );

endmodule

// ==== fp_special_case.sv ====
// special operand resolver, nan and infinity handling aligned to the sum stage
`timescale 1ns/1ps

module fp_special_case
   import fp_format_pkg::*;
   import fp_op_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        in_valid,
   input  fp_op_e      op,
   input  logic [31:0] operand_a,
   input  logic [31:0] operand_b,
   output logic        spec_hit,
   output logic        spec_invalid,
   output logic [31:0] spec_value
);

   // operand classes, subnormal counts as zero
   typedef enum logic [2:0] {
      CLS_ZERO,
      CLS_NORMAL,
      CLS_INF,
      CLS_QNAN,
      CLS_SNAN
   } fp_class_e;

   function automatic fp_class_e classify(input logic [31:0] value);
      logic [exp_width-1:0]  exp_f;
      logic [frac_width-1:0] frac_f;
      fp_class_e             cls;
      exp_f  = value[30:23];
      frac_f = value[frac_width-1:0];
      if (exp_f == '0) begin
         cls = CLS_ZERO;
      end else if (exp_f != exp_max) begin
         cls = CLS_NORMAL;
      end else if (frac_f == '0) begin
         cls = CLS_INF;
      end else if (frac_f[frac_width-1]) begin
         // quiet bit is the fraction msb
         cls = CLS_QNAN;
      end else begin
         cls = CLS_SNAN;
      end
      return cls;
   endfunction

   // stage one registers
   logic      s1_valid;
   fp_class_e s1_cls_a;
   fp_class_e s1_cls_b;
   logic      s1_sign_a;
   logic      s1_sign_b;

   // stage two selection
   logic        any_nan;
   logic        any_snan;
   logic        hit_d;
   logic        invalid_d;
   logic [31:0] value_d;

   always_ff @(posedge clk) begin
      if (reset) begin
         s1_valid <= 1'b0;
      end else begin
         s1_valid <= in_valid;
      end
   end

   always_ff @(posedge clk) begin
      s1_cls_a  <= classify(operand_a);
      s1_cls_b  <= classify(operand_b);
      s1_sign_a <= operand_a[31];
      // effective sign of b
      s1_sign_b <= operand_b[31] ^ (op == OP_SUB);
   end

   always_comb begin
      any_nan  = (s1_cls_a inside {CLS_QNAN, CLS_SNAN}) ||
                 (s1_cls_b inside {CLS_QNAN, CLS_SNAN});
      any_snan = (s1_cls_a == CLS_SNAN) || (s1_cls_b == CLS_SNAN);

      hit_d     = 1'b0;
      invalid_d = 1'b0;
      value_d   = '0;
      if (any_nan) begin
         // payloads are not propagated
         hit_d     = 1'b1;
         invalid_d = any_snan;
         value_d   = qnan_canon;
      end else if ((s1_cls_a == CLS_INF) && (s1_cls_b == CLS_INF)) begin
         hit_d = 1'b1;
         if (s1_sign_a != s1_sign_b) begin
            // inf - inf
            invalid_d = 1'b1;
            value_d   = qnan_canon;
         end else begin
            value_d = s1_sign_a ? neg_inf : pos_inf;
         end
      end else if (s1_cls_a == CLS_INF) begin
         hit_d   = 1'b1;
         value_d = s1_sign_a ? neg_inf : pos_inf;
      end else if (s1_cls_b == CLS_INF) begin
         hit_d   = 1'b1;
         value_d = s1_sign_b ? neg_inf : pos_inf;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         spec_hit     <= 1'b0;
         spec_invalid <= 1'b0;
      end else begin
         spec_hit     <= s1_valid & hit_d;
         spec_invalid <= s1_valid & invalid_d;
      end
   end

   always_ff @(posedge clk) begin
      spec_value <= value_d;
   end

   // invalid is only ever raised together with a special result
   a_invalid_needs_hit : assert property (
      @(posedge clk) disable iff (reset)
      spec_invalid |-> spec_hit
   );

endmodule

// ==== fp_sum_if.sv ====
// unrounded sum bus from the align and add stages to the round stage
`timescale 1ns/1ps

interface fp_sum_if
   import fp_format_pkg::*;
   import fp_op_pkg::*;
();

   logic                  valid;
   // sign of the result
   logic                  sign;
   // larger biased exponent
   logic [exp_width-1:0]  exp;
   // carry, hidden bit, fraction, guard, round, sticky
   logic [mant_width:0]   mant;
   round_mode_e           frm;
   // significands cancelled exactly
   logic                  exact_zero;

   modport source (output valid, sign, exp, mant, frm, exact_zero);
   modport sink   (input  valid, sign, exp, mant, frm, exact_zero);

endinterface

// ==== tb_fp_addsub.sv ====
// testbench for the single precision add and subtract pipeline, checked against an exact model
`timescale 1ns/1ps

module tb_fp_addsub
   import fp_format_pkg::*;
   import fp_op_pkg::*;
();

   // model width, enough for the largest exponent shift plus a carry
   localparam int wide         = 288;
   localparam int num_directed = 81;
   localparam int num_random   = 200;
   localparam int cycle_limit  = 2 * (num_directed + num_random) + 50;

   logic        clk;
   logic        reset;
   logic        in_valid;
   logic        op;
   logic [2:0]  frm;
   logic [31:0] operand_a;
   logic [31:0] operand_b;
   logic        out_valid;
   logic [31:0] result;
   logic [3:0]  flags;

   // expected results in issue order
   logic [31:0] res_q [$];
   logic [3:0]  flag_q [$];
   logic        head_avail = 1'b0;
   logic [31:0] head_result = '0;
   logic [3:0]  head_flags = '0;

   integer seed;
   int     issued = 0;
   int     cycles = 0;

   // operand pairs that sit between two representable values
   logic [31:0] round_a [7] = '{32'h3f80_0000, 32'h3f80_0001, 32'h3f80_0000, 32'hbf80_0000,
                                32'h3f80_0001, 32'h3fff_ffff, 32'h3f80_0000};
   logic [31:0] round_b [7] = '{32'h3380_0000, 32'h3380_0000, 32'h3300_0000, 32'h33c0_0000,
                                32'h3f80_0000, 32'h3f80_0000, 32'h3f7f_ffff};
   logic        round_sub [7] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1};

   fp_addsub_top fp_addsub_top_inst (
      .clk       (clk),
      .reset     (reset),
      .in_valid  (in_valid),
      .op        (op),
      .frm       (frm),
      .operand_a (operand_a),
      .operand_b (operand_b),
      .out_valid (out_valid),
      .result    (result),
      .flags     (flags)
   );

   always #5 clk = ~clk;

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("TESTBENCH FAILED");
      $fatal(1);
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] want);
      $display("FAILED %s got %h expected %h", name, got, want);
      $display("TESTBENCH FAILED");
      $fatal(1);
   endtask

   // exact sum in units of 2^-149, then a single rounding step
   function automatic logic [35:0] model_addsub(input logic [31:0] a, input logic [31:0] b,
                                                input logic opcode, input logic [2:0] mode);
      logic            sa;
      logic            sb;
      logic            sr;
      logic            nan_a;
      logic            nan_b;
      logic            snan;
      logic            inf_a;
      logic            inf_b;
      logic [wide-1:0] ma;
      logic [wide-1:0] mb;
      logic [wide-1:0] mag;
      logic [wide-1:0] rem;
      logic [wide-1:0] half;
      logic [24:0]     sig;
      int              msb;
      int              shift;
      int              bexp;
      logic            inexact;
      logic            up;
      logic            to_inf;
      logic [3:0]      fl;
      logic [31:0]     res;
      sa    = a[31];
      // subtract flips the sign of b
      sb    = b[31] ^ opcode;
      nan_a = (a[30:23] == 8'hff) && (a[22:0] != '0);
      nan_b = (b[30:23] == 8'hff) && (b[22:0] != '0);
      snan  = (nan_a && !a[22]) || (nan_b && !b[22]);
      inf_a = (a[30:23] == 8'hff) && (a[22:0] == '0);
      inf_b = (b[30:23] == 8'hff) && (b[22:0] == '0);
      fl    = '0;
      if (nan_a || nan_b) begin
         fl[flag_nv] = snan;
         return {fl, qnan_canon};
      end
      if (inf_a && inf_b && (sa != sb)) begin
         fl[flag_nv] = 1'b1;
         return {fl, qnan_canon};
      end
      if (inf_a) begin
         return {fl, sa, 8'hff, 23'h0};
      end
      if (inf_b) begin
         return {fl, sb, 8'hff, 23'h0};
      end
      // subnormal inputs count as zero
      ma = '0;
      mb = '0;
      if (a[30:23] != '0) begin
         ma = {{(wide-24){1'b0}}, 1'b1, a[22:0]} << (a[30:23] - 1);
      end
      if (b[30:23] != '0) begin
         mb = {{(wide-24){1'b0}}, 1'b1, b[22:0]} << (b[30:23] - 1);
      end
      if (sa == sb) begin
         mag = ma + mb;
         sr  = sa;
      end else if (ma >= mb) begin
         mag = ma - mb;
         sr  = sa;
      end else begin
         mag = mb - ma;
         sr  = sb;
      end
      if (mag == '0) begin
         // opposite signs cancel to +0, or -0 when rounding down
         sr = (sa == sb) ? sa : (mode == RDN);
         return {fl, sr, 31'h0};
      end
      msb = 0;
      for (int i = 0; i < wide; i++) begin
         if (mag[i]) begin
            msb = i;
         end
      end
      bexp = msb - 22;
      if (bexp < 1) begin
         // below the smallest normal, flush
         fl[flag_uf] = 1'b1;
         fl[flag_nx] = 1'b1;
         return {fl, sr, 31'h0};
      end
      shift   = msb - 23;
      sig     = 25'(mag >> shift);
      rem     = mag & ~({wide{1'b1}} << shift);
      half    = (shift == 0) ? '0 : ({{(wide-1){1'b0}}, 1'b1} << (shift - 1));
      inexact = (rem != '0);
      case (mode)
         RNE:     up = (rem > half) || (inexact && (rem == half) && sig[0]);
         RTZ:     up = 1'b0;
         RDN:     up = sr && inexact;
         RUP:     up = !sr && inexact;
         RMM:     up = inexact && (rem >= half);
         default: up = 1'b0;
      endcase
      sig = sig + up;
      if (sig[24]) begin
         sig  = sig >> 1;
         bexp = bexp + 1;
      end
      if (bexp >= 255) begin
         case (mode)
            RNE, RMM: to_inf = 1'b1;
            RUP:      to_inf = !sr;
            RDN:      to_inf = sr;
            default:  to_inf = 1'b0;
         endcase
         fl[flag_of] = 1'b1;
         fl[flag_nx] = 1'b1;
         res = to_inf ? {sr, 8'hff, 23'h0} : {sr, 8'hfe, 23'h7f_ffff};
      end else begin
         fl[flag_nx] = inexact;
         res = {sr, bexp[7:0], sig[22:0]};
      end
      return {fl, res};
   endfunction

   // random normal with exponent 112 to 143
   function automatic logic [31:0] mid_range_normal(input logic [31:0] bits);
      return {bits[31], 8'd112 + {3'b000, bits[30:26]}, bits[22:0]};
   endfunction

   task refresh_head();
      head_avail = (res_q.size() != 0);
      if (head_avail) begin
         head_result = res_q[0];
         head_flags  = flag_q[0];
      end
   endtask

   // drives one operation, then waits for the edge that samples it
   task automatic issue_op(input logic opcode, input logic [2:0] mode,
                           input logic [31:0] a, input logic [31:0] b);
      logic [35:0] expect_word;
      expect_word = model_addsub(a, b, opcode, mode);
      in_valid    = 1'b1;
      op          = opcode;
      frm         = mode;
      operand_a   = a;
      operand_b   = b;
      res_q.push_back(expect_word[31:0]);
      flag_q.push_back(expect_word[35:32]);
      issued++;
      refresh_head();
      @(posedge clk);
      #1;
   endtask

   task automatic drain_pipe();
      in_valid = 1'b0;
      while (res_q.size() != 0) begin
         @(posedge clk);
         #1;
      end
   endtask

   // retire the head whenever a result leaves the DUT
   always @(posedge clk) begin
      if (!reset && out_valid && (res_q.size() != 0)) begin
         void'(res_q.pop_front());
         void'(flag_q.pop_front());
         refresh_head();
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= cycle_limit) begin
         abort_run("run did not finish within the cycle limit");
      end
   end

   a_reset_clears_valid : assert property (@(posedge clk) reset |=> !out_valid)
      else abort_run("out_valid was high during or right after reset");

   a_latency : assert property (
      @(posedge clk) disable iff (reset) in_valid |-> ##pipe_latency out_valid)
      else abort_run("out_valid did not follow in_valid after the pipeline latency");

   a_no_stray_output : assert property (
      @(posedge clk) disable iff (reset) out_valid |-> $past(in_valid, pipe_latency))
      else abort_run("out_valid rose without a matching in_valid");

   a_output_expected : assert property (
      @(posedge clk) disable iff (reset) out_valid |-> head_avail)
      else abort_run("a result arrived with no operation outstanding");

   a_result_match : assert property (
      @(posedge clk) disable iff (reset) out_valid |-> (result == head_result))
      else report_mismatch("result", $sampled(result), $sampled(head_result));

   a_flags_match : assert property (
      @(posedge clk) disable iff (reset) out_valid |-> (flags == head_flags))
      else report_mismatch("flags", {28'h0, $sampled(flags)}, {28'h0, $sampled(head_flags)});

   task automatic exact_group();
      // back to back, small integers and exact zeros
      issue_op(OP_ADD, RNE, 32'h3f80_0000, 32'h4000_0000);
      issue_op(OP_SUB, RNE, 32'h40a0_0000, 32'h4040_0000);
      issue_op(OP_SUB, RNE, 32'h4040_0000, 32'h40a0_0000);
      issue_op(OP_ADD, RNE, 32'hc0e0_0000, 32'h4000_0000);
      issue_op(OP_ADD, RTZ, 32'h4120_0000, 32'h40c0_0000);
      issue_op(OP_SUB, RNE, 32'h4120_0000, 32'h4120_0000);
      issue_op(OP_SUB, RDN, 32'h4120_0000, 32'h4120_0000);
      issue_op(OP_ADD, RUP, 32'h4120_0000, 32'hc120_0000);
      issue_op(OP_ADD, RNE, 32'h8000_0000, 32'h8000_0000);
      issue_op(OP_SUB, RDN, 32'h0000_0000, 32'h0000_0000);
      drain_pipe();
      // a lone operation after an idle pipe
      issue_op(OP_ADD, RMM, 32'h3fc0_0000, 32'h3e80_0000);
      drain_pipe();
   endtask

   task automatic rounding_sweep();
      for (int p = 0; p < 7; p++) begin
         for (int m = 0; m < 5; m++) begin
            issue_op(round_sub[p], 3'(m), round_a[p], round_b[p]);
         end
      end
      drain_pipe();
   endtask

   task automatic special_operands();
      issue_op(OP_ADD, RNE, 32'h7fc1_2345, 32'h3f80_0000);
      issue_op(OP_SUB, RNE, 32'h3f80_0000, 32'h7f80_0001);
      issue_op(OP_ADD, RTZ, 32'hff81_2345, 32'h7fc0_0001);
      issue_op(OP_SUB, RNE, 32'h7f80_0000, 32'h7f80_0000);
      issue_op(OP_ADD, RUP, 32'h7f80_0000, 32'hff80_0000);
      issue_op(OP_ADD, RNE, 32'h7f80_0000, 32'h7f80_0000);
      issue_op(OP_SUB, RDN, 32'hff80_0000, 32'h7f80_0000);
      issue_op(OP_ADD, RNE, 32'h7f80_0000, 32'h3f80_0000);
      issue_op(OP_SUB, RNE, 32'h3f80_0000, 32'h7f80_0000);
      issue_op(OP_ADD, RMM, 32'hc0a0_0000, 32'h7f80_0000);
      // zero operands pass the other value through
      issue_op(OP_ADD, RNE, 32'h0000_0000, 32'h4050_0000);
      issue_op(OP_SUB, RNE, 32'h0000_0000, 32'h4050_0000);
      issue_op(OP_SUB, RDN, 32'h4050_0000, 32'h0000_0000);
      issue_op(OP_SUB, RUP, 32'h8000_0000, 32'h4000_0000);
      issue_op(OP_SUB, RNE, 32'h7fc0_0000, 32'h7f80_0000);
      drain_pipe();
   endtask

   task automatic range_limits();
      for (int m = 0; m < 5; m++) begin
         issue_op(OP_ADD, 3'(m), 32'h7f7f_ffff, 32'h7f7f_ffff);
         issue_op(OP_ADD, 3'(m), 32'hff7f_ffff, 32'hff7f_ffff);
      end
      // half an ulp above max_finite, a tie on an odd significand
      issue_op(OP_ADD, RNE, 32'h7f7f_ffff, 32'h7300_0000);
      issue_op(OP_ADD, RTZ, 32'h7f7f_ffff, 32'h7300_0000);
      // differences below the smallest normal
      issue_op(OP_SUB, RNE, 32'h0080_0001, 32'h0080_0000);
      issue_op(OP_SUB, RNE, 32'h0080_0000, 32'h0080_0001);
      issue_op(OP_SUB, RUP, 32'h00c0_0000, 32'h0080_0000);
      issue_op(OP_SUB, RDN, 32'h0100_0000, 32'h0080_0001);
      // subnormal inputs
      issue_op(OP_ADD, RNE, 32'h0000_0001, 32'h0040_0000);
      issue_op(OP_ADD, RNE, 32'h8000_0005, 32'h3f80_0000);
      issue_op(OP_SUB, RNE, 32'h0040_0000, 32'h0040_0000);
      issue_op(OP_ADD, RUP, 32'h807f_ffff, 32'h8000_0001);
      drain_pipe();
   endtask

   task automatic random_normals();
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] r;
      for (int i = 0; i < num_random; i++) begin
         a = mid_range_normal($random(seed));
         b = mid_range_normal($random(seed));
         r = $random(seed);
         issue_op(r[31], 3'(r[15:0] % 5), a, b);
      end
      drain_pipe();
   endtask

   initial begin
      clk       = 1'b0;
      reset     = 1'b1;
      in_valid  = 1'b0;
      op        = 1'b0;
      frm       = 3'd0;
      operand_a = '0;
      operand_b = '0;
      seed      = 32'h2a99_ce5a;
      repeat (2) @(posedge clk);
      #1;
      reset = 1'b0;
      // idle cycles, out_valid must stay low
      repeat (2) begin
         @(posedge clk);
         #1;
      end
      exact_group();
      rounding_sweep();
      special_operands();
      range_limits();
      random_normals();
      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule
